// ==== design/valu_pkg.sv ====
package valu_pkg;

    typedef logic [63:0] data_t;     // one register slice
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  be_t;       // one bit per data byte
    typedef logic [7:0]  vl_t;
    typedef logic [1:0]  sew_t;      // 0: 8b, 1: 16b, 2: 32b, 3: 64b
    typedef logic [5:0]  func_id_t;
    typedef logic [3:0]  alu_op_t;

    // decoded operation classes
    localparam alu_op_t op_add   = 4'd0;
    localparam alu_op_t op_sub   = 4'd1;
    localparam alu_op_t op_rsub  = 4'd2;
    localparam alu_op_t op_minu  = 4'd3;
    localparam alu_op_t op_min   = 4'd4;
    localparam alu_op_t op_maxu  = 4'd5;
    localparam alu_op_t op_max   = 4'd6;
    localparam alu_op_t op_and   = 4'd7;
    localparam alu_op_t op_or    = 4'd8;
    localparam alu_op_t op_xor   = 4'd9;
    localparam alu_op_t op_move  = 4'd10;
    localparam alu_op_t op_merge = 4'd11;

    // request function codes
    localparam func_id_t fn_add  = 6'd0;
    localparam func_id_t fn_sub  = 6'd2;
    localparam func_id_t fn_rsub = 6'd3;
    localparam func_id_t fn_minu = 6'd4;
    localparam func_id_t fn_min  = 6'd5;
    localparam func_id_t fn_maxu = 6'd6;
    localparam func_id_t fn_max  = 6'd7;
    localparam func_id_t fn_and  = 6'd9;
    localparam func_id_t fn_or   = 6'd10;
    localparam func_id_t fn_xor  = 6'd11;
    localparam func_id_t fn_mv   = 6'd23;  // move or merge, split by mask

endpackage

// ==== design/valu_ifs.sv ====
`timescale 1ns/1ns

interface valu_op_if;
    logic               valid;
    valu_pkg::alu_op_t  op;
    valu_pkg::sew_t     sew;
    valu_pkg::data_t    data0;
    valu_pkg::data_t    data1;
    valu_pkg::addr_t    addr;
    valu_pkg::be_t      be;
    valu_pkg::vl_t      vl;

    modport src (output valid, op, sew, data0, data1, addr, be, vl);
    modport dst (input  valid, op, sew, data0, data1, addr, be, vl);
endinterface

interface valu_res_if;
    logic               valid;
    valu_pkg::data_t    data;
    valu_pkg::addr_t    addr;
    valu_pkg::be_t      be;
    valu_pkg::vl_t      vl;

    modport src (output valid, data, addr, be, vl);
    modport dst (input  valid, data, addr, be, vl);
endinterface

// ==== design/valu_decode.sv ====
`timescale 1ns/1ns

module valu_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  valu_pkg::func_id_t  req_func_id,
    input  logic                req_mask,
    input  valu_pkg::sew_t      req_sew,
    input  valu_pkg::data_t     req_data0,
    input  valu_pkg::data_t     req_data1,
    input  valu_pkg::addr_t     req_addr,
    input  valu_pkg::be_t       req_be,
    input  valu_pkg::vl_t       req_vl,
    valu_op_if.src              op_out
);

    valu_pkg::alu_op_t dec_op;
    logic              dec_known;

    always_comb begin
        dec_known = 1'b1;
        dec_op    = valu_pkg::op_add;
        case (req_func_id)
            valu_pkg::fn_add:  dec_op = valu_pkg::op_add;
            valu_pkg::fn_sub:  dec_op = valu_pkg::op_sub;
            valu_pkg::fn_rsub: dec_op = valu_pkg::op_rsub;
            valu_pkg::fn_minu: dec_op = valu_pkg::op_minu;
            valu_pkg::fn_min:  dec_op = valu_pkg::op_min;
            valu_pkg::fn_maxu: dec_op = valu_pkg::op_maxu;
            valu_pkg::fn_max:  dec_op = valu_pkg::op_max;
            valu_pkg::fn_and:  dec_op = valu_pkg::op_and;
            valu_pkg::fn_or:   dec_op = valu_pkg::op_or;
            valu_pkg::fn_xor:  dec_op = valu_pkg::op_xor;
            valu_pkg::fn_mv:   dec_op = req_mask ? valu_pkg::op_merge : valu_pkg::op_move;
            default:           dec_known = 1'b0;  // request gets dropped
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_out.valid <= 1'b0;
            op_out.op    <= '0;
            op_out.sew   <= '0;
            op_out.data0 <= '0;
            op_out.data1 <= '0;
            op_out.addr  <= '0;
            op_out.be    <= '0;
            op_out.vl    <= '0;
        end else begin
            op_out.valid <= req_valid & dec_known;
            op_out.op    <= dec_op;
            op_out.sew   <= req_sew;
            op_out.data0 <= req_data0;
            op_out.data1 <= req_data1;
            op_out.addr  <= req_addr;
            op_out.be    <= req_be;
            op_out.vl    <= req_vl;
        end
    end

endmodule

// ==== design/valu_lane_alu.sv ====
`timescale 1ns/1ns

module valu_lane_alu (
    input  logic      clk,
    input  logic      rst,
    valu_op_if.dst    op_in,
    valu_res_if.src   res_out
);

    // element-wise arithmetic and min/max for one fixed element width
    function automatic valu_pkg::data_t lane_calc(
        input valu_pkg::alu_op_t op,
        input valu_pkg::data_t   a,
        input valu_pkg::data_t   b,
        input int                ew
    );
        valu_pkg::data_t m;
        valu_pkg::data_t sbit;
        valu_pkg::data_t ea;
        valu_pkg::data_t eb;
        valu_pkg::data_t er;
        valu_pkg::data_t res;
        logic            lt_u;
        logic            lt_s;
        m    = {64{1'b1}} >> (64 - ew);
        sbit = 64'd1 << (ew - 1);
        res  = '0;
        for (int i = 0; i < 8; i++) begin
            if (i * ew < 64) begin
                ea   = (a >> (i * ew)) & m;
                eb   = (b >> (i * ew)) & m;
                lt_u = ea < eb;
                lt_s = (ea ^ sbit) < (eb ^ sbit);  // sign flip turns signed into unsigned order
                case (op)
                    valu_pkg::op_add:  er = ea + eb;
                    valu_pkg::op_sub:  er = ea - eb;  // data0 - data1
                    valu_pkg::op_rsub: er = eb - ea;  // data1 - data0
                    valu_pkg::op_minu: er = lt_u ? ea : eb;
                    valu_pkg::op_min:  er = lt_s ? ea : eb;
                    valu_pkg::op_maxu: er = lt_u ? eb : ea;
                    valu_pkg::op_max:  er = lt_s ? eb : ea;
                    default:           er = '0;
                endcase
                res = res | ((er & m) << (i * ew));  // carries die at the mask
            end
        end
        return res;
    endfunction

    valu_pkg::data_t elem_res [4];
    valu_pkg::data_t result;

    // one candidate per element width, picked by sew below
    for (genvar g = 0; g < 4; g++) begin : g_sew
        assign elem_res[g] = lane_calc(op_in.op, op_in.data0, op_in.data1, 8 << g);
    end

    always_comb begin
        result = elem_res[op_in.sew];
        case (op_in.op)
            valu_pkg::op_and:  result = op_in.data0 & op_in.data1;
            valu_pkg::op_or:   result = op_in.data0 | op_in.data1;
            valu_pkg::op_xor:  result = op_in.data0 ^ op_in.data1;
            valu_pkg::op_move: result = op_in.data0;
            valu_pkg::op_merge: begin
                for (int k = 0; k < 8; k++) begin
                    result[k*8 +: 8] = op_in.be[k] ? op_in.data0[k*8 +: 8]
                                                   : op_in.data1[k*8 +: 8];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_out.valid <= 1'b0;
            res_out.data  <= '0;
            res_out.addr  <= '0;
            res_out.be    <= '0;
            res_out.vl    <= '0;
        end else begin
            res_out.valid <= op_in.valid;
            res_out.data  <= result;
            res_out.addr  <= op_in.addr;  // side fields ride along untouched
            res_out.be    <= op_in.be;
            res_out.vl    <= op_in.vl;
        end
    end

endmodule

// ==== design/valu_resp_stage.sv ====
`timescale 1ns/1ns

module valu_resp_stage (
    input  logic             clk,
    input  logic             rst,
    valu_res_if.dst          res_in,
    output logic             resp_valid,
    output valu_pkg::data_t  resp_data,
    output valu_pkg::addr_t  resp_addr,
    output valu_pkg::be_t    resp_be,
    output valu_pkg::vl_t    resp_vl
);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_addr  <= '0;
            resp_be    <= '0;
            resp_vl    <= '0;
        end else begin
            resp_valid <= res_in.valid;
            if (res_in.valid) begin  // hold last result between responses
                resp_data <= res_in.data;
                resp_addr <= res_in.addr;
                resp_be   <= res_in.be;
                resp_vl   <= res_in.vl;
            end
        end
    end

endmodule

// ==== design/valu_top.sv ====
`timescale 1ns/1ns

module valu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  valu_pkg::func_id_t  req_func_id,
    input  logic                req_mask,
    input  valu_pkg::sew_t      req_sew,
    input  valu_pkg::data_t     req_data0,
    input  valu_pkg::data_t     req_data1,
    input  valu_pkg::addr_t     req_addr,
    input  valu_pkg::be_t       req_be,
    input  valu_pkg::vl_t       req_vl,
    output logic                resp_valid,
    output valu_pkg::data_t     resp_data,
    output valu_pkg::addr_t     resp_addr,
    output valu_pkg::be_t       resp_be,
    output valu_pkg::vl_t       resp_vl
);

    valu_op_if  op_bus ();   // decode -> alu
    valu_res_if res_bus ();  // alu -> response register

    valu_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_mask    (req_mask),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .op_out      (op_bus.src)
    );

    valu_lane_alu u_lane_alu (
        .clk     (clk),
        .rst     (rst),
        .op_in   (op_bus.dst),
        .res_out (res_bus.src)
    );

    valu_resp_stage u_resp_stage (
        .clk        (clk),
        .rst        (rst),
        .res_in     (res_bus.dst),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_addr  (resp_addr),
        .resp_be    (resp_be),
        .resp_vl    (resp_vl)
    );

endmodule

// ==== verification/valu_model.svh ====
`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

typedef struct packed {
    valu_pkg::data_t data;
    valu_pkg::addr_t addr;
    valu_pkg::be_t   be;
    valu_pkg::vl_t   vl;
    logic [31:0]     cyc;   // cycle the request was driven in
} exp_resp_t;

exp_resp_t exp_q [$];

function automatic bit code_known(input valu_pkg::func_id_t fn);
    case (fn)
        valu_pkg::fn_add, valu_pkg::fn_sub, valu_pkg::fn_rsub,
        valu_pkg::fn_minu, valu_pkg::fn_min, valu_pkg::fn_maxu, valu_pkg::fn_max,
        valu_pkg::fn_and, valu_pkg::fn_or, valu_pkg::fn_xor,
        valu_pkg::fn_mv: return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

// only the low ew bits of the result matter
function automatic valu_pkg::data_t elem_result(
    input valu_pkg::func_id_t fn,
    input valu_pkg::data_t    x,
    input valu_pkg::data_t    y,
    input int                 ew
);
    valu_pkg::data_t xh;
    valu_pkg::data_t yh;
    xh = x << (64 - ew);  // element moved to the top, so 64-bit compares order it
    yh = y << (64 - ew);
    case (fn)
        valu_pkg::fn_add:  return x + y;
        valu_pkg::fn_sub:  return x - y;
        valu_pkg::fn_rsub: return y - x;
        valu_pkg::fn_minu: return (xh < yh) ? x : y;
        valu_pkg::fn_min:  return ($signed(xh) < $signed(yh)) ? x : y;
        valu_pkg::fn_maxu: return (xh > yh) ? x : y;
        valu_pkg::fn_max:  return ($signed(xh) > $signed(yh)) ? x : y;
        default:           return '0;
    endcase
endfunction

function automatic valu_pkg::data_t expect_data(
    input valu_pkg::func_id_t fn,
    input logic               mask,
    input valu_pkg::sew_t     sew,
    input valu_pkg::data_t    a,
    input valu_pkg::data_t    b,
    input valu_pkg::be_t      be
);
    int              ew;
    valu_pkg::data_t r;
    valu_pkg::data_t res;
    ew  = 8 << sew;
    res = '0;
    case (fn)
        valu_pkg::fn_and: res = a & b;
        valu_pkg::fn_or:  res = a | b;
        valu_pkg::fn_xor: res = a ^ b;
        valu_pkg::fn_mv: begin
            for (int i = 0; i < 64; i++) begin
                res[i] = (mask && !be[i / 8]) ? b[i] : a[i];  // merge picks data1 on clear be
            end
        end
        default: begin
            for (int base = 0; base < 64; base += ew) begin
                r = elem_result(fn, a >> base, b >> base, ew);
                for (int k = 0; k < ew; k++) begin
                    res[base + k] = r[k];
                end
            end
        end
    endcase
    return res;
endfunction

`endif

// ==== verification/valu_tb.sv ====
`timescale 1ns/1ns

module valu_tb;

    localparam int reqs_per_test   = 200;
    localparam int total_reqs      = 5 * reqs_per_test;
    localparam int watchdog_cycles = total_reqs * 10 + 100;

    logic               clk = 1'b0;
    logic               rst;
    logic               req_valid;
    valu_pkg::func_id_t req_func_id;
    logic               req_mask;
    valu_pkg::sew_t     req_sew;
    valu_pkg::data_t    req_data0;
    valu_pkg::data_t    req_data1;
    valu_pkg::addr_t    req_addr;
    valu_pkg::be_t      req_be;
    valu_pkg::vl_t      req_vl;
    logic               resp_valid;
    valu_pkg::data_t    resp_data;
    valu_pkg::addr_t    resp_addr;
    valu_pkg::be_t      resp_be;
    valu_pkg::vl_t      resp_vl;

    logic [31:0] cycle = '0;
    int          err_count = 0;
    int          test_err_start = 0;
    int          pass_tests = 0;
    int          fail_tests = 0;
    int unsigned seed_dummy;

    // arith 0..2, min/max 3..6, logic 7..9, move/merge 10
    valu_pkg::func_id_t valid_fns [11] = '{
        valu_pkg::fn_add, valu_pkg::fn_sub, valu_pkg::fn_rsub,
        valu_pkg::fn_minu, valu_pkg::fn_min, valu_pkg::fn_maxu, valu_pkg::fn_max,
        valu_pkg::fn_and, valu_pkg::fn_or, valu_pkg::fn_xor, valu_pkg::fn_mv
    };

    `include "valu_model.svh"

    exp_resp_t held_resp = '0;  // what the response register shows while idle

    valu_top dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    task automatic check_data(input string name, input valu_pkg::data_t want,
                              input valu_pkg::data_t got);
        if (got !== want) begin
            $display("ERR %s expected %h got %h", name, want, got);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input valu_pkg::addr_t want,
                              input valu_pkg::addr_t got);
        if (got !== want) begin
            $display("ERR %s expected %h got %h", name, want, got);
            err_count++;
        end
    endtask

    task automatic check_be(input string name, input valu_pkg::be_t want,
                            input valu_pkg::be_t got);
        if (got !== want) begin
            $display("ERR %s expected %h got %h", name, want, got);
            err_count++;
        end
    endtask

    task automatic check_vl(input string name, input valu_pkg::vl_t want,
                            input valu_pkg::vl_t got);
        if (got !== want) begin
            $display("ERR %s expected %h got %h", name, want, got);
            err_count++;
        end
    endtask

    task automatic check_outputs();
        exp_resp_t e;
        if (resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("response with no request pending, data %h", resp_data);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                check_data("resp_data", e.data, resp_data);
                check_addr("resp_addr", e.addr, resp_addr);
                check_be("resp_be", e.be, resp_be);
                check_vl("resp_vl", e.vl, resp_vl);
                if (cycle - e.cyc != 32'd3) begin
                    $display("request from cycle %0d answered after %0d cycles instead of 3",
                             e.cyc, cycle - e.cyc);
                    err_count++;
                end
                held_resp = e;
            end
        end else if (resp_valid === 1'b0) begin
            check_data("resp_data", held_resp.data, resp_data);  // fields hold between responses
            check_addr("resp_addr", held_resp.addr, resp_addr);
            check_be("resp_be", held_resp.be, resp_be);
            check_vl("resp_vl", held_resp.vl, resp_vl);
        end else begin
            $display("resp_valid is unknown at cycle %0d", cycle);
            err_count++;
        end
    endtask

    // outputs are stable at the falling edge, inputs change right after
    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle_cycle();
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic send_req(input valu_pkg::func_id_t fn, input logic mask,
                            input valu_pkg::sew_t sew, input valu_pkg::data_t d0,
                            input valu_pkg::data_t d1);
        valu_pkg::be_t   be;
        valu_pkg::addr_t addr;
        valu_pkg::vl_t   vl;
        be   = $urandom;
        addr = $urandom;
        vl   = $urandom;
        next_cycle();
        req_valid   = 1'b1;
        req_func_id = fn;
        req_mask    = mask;
        req_sew     = sew;
        req_data0   = d0;
        req_data1   = d1;
        req_addr    = addr;
        req_be      = be;
        req_vl      = vl;
        if (code_known(fn)) begin  // unknown codes never answer
            exp_q.push_back({expect_data(fn, mask, sew, d0, d1, be), addr, be, vl, cycle});
        end
    endtask

    task automatic apply_reset(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            rst       = 1'b1;
            req_valid = 1'b0;
            exp_q.delete();  // whatever was in flight is lost
            held_resp = '0;  // response register clears to zero
        end
        next_cycle();
        rst = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            idle_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            err_count++;
            exp_q.delete();
        end
        repeat (3) idle_cycle();  // stray responses show up here
    endtask

    task automatic end_test(input string name);
        int errs;
        drain();
        errs = err_count - test_err_start;
        if (errs == 0) pass_tests++;
        else fail_tests++;
        $display("test %s finished with %0d errors", name, errs);
        test_err_start = err_count;
    endtask

    function automatic valu_pkg::data_t rand_data();
        return {$urandom, $urandom};
    endfunction

    // bytes pulled toward the sign boundaries
    function automatic valu_pkg::data_t edge_data();
        valu_pkg::data_t d;
        for (int i = 0; i < 8; i++) begin
            case ($urandom % 6)
                0:       d[i*8 +: 8] = 8'h00;
                1:       d[i*8 +: 8] = 8'h7f;
                2:       d[i*8 +: 8] = 8'h80;
                3:       d[i*8 +: 8] = 8'hff;
                default: d[i*8 +: 8] = $urandom;
            endcase
        end
        return d;
    endfunction

    initial begin
        #(watchdog_cycles * 10);
        $display("watchdog ran out of time, the run did not finish");
        $display("Something failed");
        $finish;
    end

    initial begin
        seed_dummy  = $urandom(32'h44fb);
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_mask    = 1'b0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        apply_reset(10);

        for (int i = 0; i < reqs_per_test; i++) begin
            send_req(valid_fns[$urandom % 3], $urandom % 2, i % 4, rand_data(), rand_data());
            if ($urandom % 4 == 0) idle_cycle();
        end
        end_test("arithmetic");

        for (int i = 0; i < reqs_per_test; i++) begin
            send_req(valid_fns[3 + $urandom % 4], $urandom % 2, i % 4, edge_data(), edge_data());
            if ($urandom % 4 == 0) idle_cycle();
        end
        end_test("min_max");

        for (int i = 0; i < reqs_per_test; i++) begin
            case (i % 3)
                0: send_req(valid_fns[7 + $urandom % 3], $urandom % 2, $urandom % 4,
                            rand_data(), rand_data());
                1: send_req(valu_pkg::fn_mv, 1'b0, $urandom % 4, rand_data(), rand_data());
                default: send_req(valu_pkg::fn_mv, 1'b1, $urandom % 4, rand_data(), rand_data());
            endcase
        end
        end_test("logic_move_merge");

        for (int i = 0; i < reqs_per_test; i++) begin
            send_req(valid_fns[$urandom % 11], $urandom % 2, $urandom % 4,
                     rand_data(), rand_data());
        end
        end_test("back_to_back");

        for (int i = 0; i < reqs_per_test; i++) begin
            if (i == reqs_per_test / 2) begin
                apply_reset(10);
                repeat (3) idle_cycle();
            end
            send_req(($urandom % 2) ? valu_pkg::func_id_t'($urandom) : valid_fns[$urandom % 11],
                     $urandom % 2, $urandom % 4, rand_data(), rand_data());
        end
        end_test("unknown_codes_reset");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verification
design/valu_pkg.sv
design/valu_ifs.sv
design/valu_decode.sv
design/valu_lane_alu.sv
design/valu_resp_stage.sv
design/valu_top.sv
verification/valu_tb.sv

// ==== Bender.yml ====
package:
  name: valu

sources:
  - design/valu_pkg.sv
  - design/valu_ifs.sv
  - design/valu_decode.sv
  - design/valu_lane_alu.sv
  - design/valu_resp_stage.sv
  - design/valu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/valu_tb.sv
